/* verilog/controlUnit_config.svh */
`ifndef CONTROLUNIT_CONFIG_SVH
`define CONTROLUNIT_CONFIG_SVH

// ****************************************
// Instruction word fields
// ****************************************

`define OPCODE_WIDTH 6       // Instruction bits 31:26
`define FUNCT_WIDTH 6        // Low bits of the offset field
`define OFFSET_WIDTH 16      // Instruction bits 15:0

// ****************************************
// Sequencer
// ****************************************

`define STEP_WIDTH 3         // Longest phase is fetch with six steps

`endif

/* verilog/isaPkg.sv */
`include "controlUnit_config.svh"

package isaPkg;

    // ****************************************
    // Opcode and funct encodings
    // ****************************************

    typedef enum logic [`OPCODE_WIDTH-1:0] {
        opR    = 6'b000000,
        opJump = 6'b000010,
        opAddi = 6'b001000,
        opHalt = 6'b111111    // Freezes the unit until reset
    } opcodeT;

    typedef enum logic [`FUNCT_WIDTH-1:0] {
        fnSll = 6'b000000,
        fnAdd = 6'b100000,
        fnSub = 6'b100010,
        fnAnd = 6'b100100,
        fnSlt = 6'b101010
    } functT;

    // One class per execute sequence
    typedef enum logic [3:0] {
        clsAdd,
        clsSub,
        clsAnd,
        clsSll,
        clsSlt,
        clsAddi,
        clsJump,
        clsHalt,
        clsInvalid            // Refetch
    } instrClassT;

endpackage

/* verilog/controlPkg.sv */
package controlPkg;

    // ****************************************
    // Sequencer phases
    // ****************************************

    typedef enum logic [3:0] {
        phFetch,              // Fetch, register read and decode
        phAdd,
        phSub,
        phAnd,
        phSll,
        phSlt,
        phAddi,
        phJump,
        phHalt
    } phaseT;

    // ****************************************
    // Datapath selects
    // ****************************************

    typedef enum logic [2:0] {
        aluNone = 3'b000,
        aluAdd  = 3'b001,
        aluSub  = 3'b010,
        aluAnd  = 3'b011,
        aluLess = 3'b111
    } aluOpT;

    typedef enum logic [1:0] {
        srcBRegB = 2'b00,
        srcBFour = 2'b01,     // PC increment
        srcBImm  = 2'b10      // Sign-extended offset
    } srcBT;

    typedef enum logic [1:0] {
        destRt = 2'b00,
        destRd = 2'b01
    } regDestT;

    // Write-back source
    typedef enum logic [3:0] {
        wbAluOut = 4'b0000,
        wbLess   = 4'b0100,
        wbShift  = 4'b1000
    } memToRegT;

    typedef enum logic [2:0] {
        shNone = 3'b000,
        shLoad = 3'b001,
        shLeft = 3'b010
    } shiftOpT;

endpackage

/* verilog/instrDecoder.sv */
`timescale 1ns/1ps

module instrDecoder (
    input  isaPkg::opcodeT     opcode,
    input  isaPkg::functT      funct,
    output isaPkg::instrClassT instrClass
);
    import isaPkg::*;

    // ****************************************
    // R-type split by funct
    // ****************************************

    instrClassT rClass;

    always_comb begin
        case (funct)
            fnAdd:   rClass = clsAdd;
            fnSub:   rClass = clsSub;
            fnAnd:   rClass = clsAnd;
            fnSll:   rClass = clsSll;
            fnSlt:   rClass = clsSlt;
            default: rClass = clsInvalid;
        endcase
    end

    // ****************************************
    // Opcode map
    // ****************************************

    always_comb begin
        case (opcode)
            opR:     instrClass = rClass;
            opAddi:  instrClass = clsAddi;
            opJump:  instrClass = clsJump;
            opHalt:  instrClass = clsHalt;
            default: instrClass = clsInvalid;   // Unknown opcode
        endcase
    end

endmodule

/* verilog/stepSequencer.sv */
`timescale 1ns/1ps
`include "controlUnit_config.svh"

module stepSequencer (
    input  logic                   clock,
    input  logic                   reset,
    input  isaPkg::instrClassT     instrClass,
    output controlPkg::phaseT      phase,
    output logic [`STEP_WIDTH-1:0] step
);
    import isaPkg::*;
    import controlPkg::*;

    localparam logic [`STEP_WIDTH-1:0] decodeStep = `STEP_WIDTH'(5);

    phaseT                  phaseNext;
    logic [`STEP_WIDTH-1:0] stepNext;
    logic [`STEP_WIDTH-1:0] lastStep;

    // Execute phase chosen at decode
    function automatic phaseT executePhase(input instrClassT cls);
        case (cls)
            clsAdd:  return phAdd;
            clsSub:  return phSub;
            clsAnd:  return phAnd;
            clsSll:  return phSll;
            clsSlt:  return phSlt;
            clsAddi: return phAddi;
            clsJump: return phJump;
            clsHalt: return phHalt;
            default: return phFetch;     // Invalid class refetches
        endcase
    endfunction

    // Final step of each execute phase
    always_comb begin
        case (phase)
            phAdd, phSub, phAnd, phAddi: lastStep = `STEP_WIDTH'(1);
            phSll:                       lastStep = `STEP_WIDTH'(2);
            default:                     lastStep = '0;   // slt and j
        endcase
    end

    always_comb begin
        phaseNext = phase;
        stepNext  = step + 1'b1;
        case (phase)
            phFetch: begin
                if (step == decodeStep) begin
                    phaseNext = executePhase(instrClass);
                    stepNext  = '0;
                end
            end
            phHalt: begin
                stepNext = step;                  // Frozen until reset
            end
            default: begin
                if (step == lastStep) begin
                    phaseNext = phFetch;
                    stepNext  = '0;
                end
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            phase <= phFetch;
            step  <= '0;
        end else begin
            phase <= phaseNext;
            step  <= stepNext;
        end
    end

endmodule

/* verilog/controlWordGen.sv */
`timescale 1ns/1ps
`include "controlUnit_config.svh"

module controlWordGen (
    input  logic                   reset,
    input  controlPkg::phaseT      phase,
    input  logic [`STEP_WIDTH-1:0] step,
    output logic                   pcWrite,
    output logic                   irWrite,
    output logic                   regWrite,
    output logic                   aWrite,
    output logic                   bWrite,
    output logic                   aluOutWrite,
    output logic                   srcASelect,
    output logic                   pcSource,
    output logic                   shiftAmtSelect,
    output logic                   shiftSrcSelect,
    output logic                   resetOut,
    output controlPkg::aluOpT      aluOp,
    output controlPkg::srcBT       srcBSelect,
    output controlPkg::regDestT    regDestSelect,
    output controlPkg::memToRegT   memToRegSelect,
    output controlPkg::shiftOpT    shiftOp
);
    import controlPkg::*;

    localparam logic [`STEP_WIDTH-1:0] pcStep      = `STEP_WIDTH'(3);
    localparam logic [`STEP_WIDTH-1:0] regReadStep = `STEP_WIDTH'(4);
    localparam logic [`STEP_WIDTH-1:0] writeStep   = `STEP_WIDTH'(1);
    localparam logic [`STEP_WIDTH-1:0] shiftLast   = `STEP_WIDTH'(2);

    always_comb begin
        pcWrite        = 1'b0;
        irWrite        = 1'b0;
        regWrite       = 1'b0;
        aWrite         = 1'b0;
        bWrite         = 1'b0;
        aluOutWrite    = 1'b0;
        srcASelect     = 1'b0;
        pcSource       = 1'b0;
        shiftAmtSelect = 1'b0;
        shiftSrcSelect = 1'b0;
        resetOut       = 1'b0;
        aluOp          = aluNone;
        srcBSelect     = srcBRegB;
        regDestSelect  = destRt;
        memToRegSelect = wbAluOut;
        shiftOp        = shNone;

        if (reset || phase == phHalt) begin
            resetOut = 1'b1;                       // Everything else stays low
        end else begin
            case (phase)
                // ****************************************
                // Fetch, register read, decode
                // ****************************************
                phFetch: begin
                    if (step <= pcStep) begin
                        aluOp      = aluAdd;       // PC + 4
                        srcBSelect = srcBFour;
                    end
                    if (step == pcStep) begin
                        pcWrite = 1'b1;
                        irWrite = 1'b1;
                    end
                    if (step == regReadStep) begin
                        aWrite     = 1'b1;
                        bWrite     = 1'b1;
                        srcBSelect = srcBFour;
                    end
                end

                // ****************************************
                // Execute
                // ****************************************
                phAdd, phSub, phAnd: begin
                    if (phase == phSub) begin
                        aluOp = aluSub;
                    end else if (phase == phAnd) begin
                        aluOp = aluAnd;
                    end else begin
                        aluOp = aluAdd;
                    end
                    aluOutWrite = 1'b1;
                    srcASelect  = 1'b1;
                    srcBSelect  = srcBRegB;
                    if (step == writeStep) begin
                        regWrite      = 1'b1;
                        regDestSelect = destRd;
                    end
                end
                phAddi: begin
                    aluOp      = aluAdd;
                    srcASelect = 1'b1;
                    if (step == writeStep) begin
                        regWrite      = 1'b1;
                        regDestSelect = destRt;
                    end else begin
                        aluOutWrite = 1'b1;
                        srcBSelect  = srcBImm;
                    end
                end
                phSll: begin
                    regDestSelect  = destRd;
                    memToRegSelect = wbShift;
                    if (step == '0) begin
                        shiftOp        = shLoad;   // Load rt, amount from shamt
                        shiftAmtSelect = 1'b1;
                        shiftSrcSelect = 1'b1;
                    end else begin
                        shiftOp  = shLeft;
                        regWrite = (step == shiftLast);
                    end
                end
                phSlt: begin
                    aluOp          = aluLess;
                    srcASelect     = 1'b1;
                    regDestSelect  = destRd;
                    memToRegSelect = wbLess;
                    regWrite       = 1'b1;
                end
                phJump: begin
                    pcWrite  = 1'b1;
                    pcSource = 1'b1;               // Jump target
                end
                default: ;
            endcase
        end
    end

endmodule

/* verilog/controlUnit.sv */
`timescale 1ns/1ps
`include "controlUnit_config.svh"

module controlUnit (
    input  logic                     clock,
    input  logic                     reset,
    input  logic [`OPCODE_WIDTH-1:0] opcode,
    input  logic [`OFFSET_WIDTH-1:0] offset,
    output logic                     pcWrite,
    output logic                     irWrite,
    output logic                     regWrite,
    output logic                     aWrite,
    output logic                     bWrite,
    output logic                     aluOutWrite,
    output logic                     srcASelect,
    output logic                     pcSource,
    output logic                     shiftAmtSelect,
    output logic                     shiftSrcSelect,
    output logic                     resetOut,
    output controlPkg::aluOpT        aluOp,
    output controlPkg::srcBT         srcBSelect,
    output controlPkg::regDestT      regDestSelect,
    output controlPkg::memToRegT     memToRegSelect,
    output controlPkg::shiftOpT      shiftOp
);
    import isaPkg::*;
    import controlPkg::*;

    instrClassT             instrClass;
    phaseT                  phase;
    logic [`STEP_WIDTH-1:0] step;

    instrDecoder decoder_i (
        .opcode     (opcodeT'(opcode)),
        .funct      (functT'(offset[`FUNCT_WIDTH-1:0])),   // Only funct bits decode
        .instrClass (instrClass)
    );

    stepSequencer sequencer_i (
        .clock      (clock),
        .reset      (reset),
        .instrClass (instrClass),
        .phase      (phase),
        .step       (step)
    );

    controlWordGen wordGen_i (
        .reset          (reset),
        .phase          (phase),
        .step           (step),
        .pcWrite        (pcWrite),
        .irWrite        (irWrite),
        .regWrite       (regWrite),
        .aWrite         (aWrite),
        .bWrite         (bWrite),
        .aluOutWrite    (aluOutWrite),
        .srcASelect     (srcASelect),
        .pcSource       (pcSource),
        .shiftAmtSelect (shiftAmtSelect),
        .shiftSrcSelect (shiftSrcSelect),
        .resetOut       (resetOut),
        .aluOp          (aluOp),
        .srcBSelect     (srcBSelect),
        .regDestSelect  (regDestSelect),
        .memToRegSelect (memToRegSelect),
        .shiftOp        (shiftOp)
    );

endmodule

/* tb/clockGen.sv */
`timescale 1ns/1ps

module clockGen (
    input  logic resetRequest,
    output logic clock,
    output logic reset
);
    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;            // 20 ns period
    end

    // Five reset cycles at start and again on each request
    initial begin
        reset = 1'b1;
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset <= 1'b0;
        forever begin
            @(posedge resetRequest);
            @(negedge clock);
            reset <= 1'b1;
            repeat (5) @(posedge clock);
            @(negedge clock);
            reset <= 1'b0;
        end
    end

endmodule

/* tb/controlUnit_sva.sv */
`timescale 1ns/1ps
`include "controlUnit_config.svh"

module controlUnitAssertions (
    input logic                   clock,
    input controlPkg::phaseT      phase,
    input logic [`STEP_WIDTH-1:0] step,
    input logic                   pcWrite,
    input logic                   irWrite,
    input logic                   regWrite,
    input logic                   aWrite,
    input logic                   bWrite,
    input logic                   aluOutWrite,
    input logic                   resetOut
);
    import controlPkg::*;

    int failureCount = 0;

    // IR loads only together with the PC update of fetch step 3
    pcIrTogether: assert property (@(posedge clock)
        (pcWrite && irWrite) |-> (phase == phFetch && step == `STEP_WIDTH'(3)))
        else begin
            failureCount++;
            $error("pcWrite and irWrite both high outside fetch step 3");
        end

    regWriteVsRead: assert property (@(posedge clock) !(regWrite && aWrite))
        else begin
            failureCount++;
            $error("regWrite and aWrite high in the same cycle");
        end

    resetQuiet: assert property (@(posedge clock)
        resetOut |-> !(pcWrite || irWrite || regWrite || aWrite || bWrite || aluOutWrite))
        else begin
            failureCount++;
            $error("Strobe high while resetOut is high");
        end

endmodule

/* tb/controlUnitTb.sv */
`timescale 1ns/1ps
`include "controlUnit_config.svh"

module controlUnitTb;
    import isaPkg::*;
    import controlPkg::*;

    localparam int randomCount = 150;
    localparam int instrCount  = 1 + 9 + randomCount + 3;   // Reset, directed, random, halt
    localparam int cycleNs     = 20;
    localparam int rstBit = 0, shSrcBit = 1, shAmtBit = 2, pcSrcBit = 3, srcABit = 4,
                   aluOutBit = 5, bBit = 6, aBit = 7, regBit = 8, irBit = 9, pcBit = 10;

    typedef struct packed {
        logic [10:0] strobes;
        aluOpT       aluOp;
        srcBT        srcB;
        regDestT     regDest;
        memToRegT    memToReg;
        shiftOpT     shiftOp;
    } wordT;

    logic                     clock;
    logic                     reset;
    logic                     resetRequest;
    logic [`OPCODE_WIDTH-1:0] opcode;
    logic [`OFFSET_WIDTH-1:0] offset;
    logic pcWrite, irWrite, regWrite, aWrite, bWrite, aluOutWrite;
    logic srcASelect, pcSource, shiftAmtSelect, shiftSrcSelect, resetOut;
    aluOpT                    aluOp;
    srcBT                     srcBSelect;
    regDestT                  regDestSelect;
    memToRegT                 memToRegSelect;
    shiftOpT                  shiftOp;

    phaseT                  modelPhase   = phFetch;
    logic [`STEP_WIDTH-1:0] modelStep    = '0;
    instrClassT             currentClass = clsAdd;
    logic [31:0]            seed         = 32'd59251;
    int                     errorCount   = 0;
    int                     haltCycles   = 0;

    string      strobeNames [11] = '{"resetOut", "shiftSrcSelect", "shiftAmtSelect", "pcSource",
                                     "srcASelect", "aluOutWrite", "bWrite", "aWrite",
                                     "regWrite", "irWrite", "pcWrite"};
    functT      rFuncts     [5]  = '{fnAdd, fnSub, fnAnd, fnSll, fnSlt};
    instrClassT rClasses    [5]  = '{clsAdd, clsSub, clsAnd, clsSll, clsSlt};
    logic [5:0] badOpcodes  [4]  = '{6'h01, 6'h04, 6'h23, 6'h2b};
    logic [5:0] badFuncts   [4]  = '{6'h02, 6'h03, 6'h21, 6'h26};

    clockGen clock_i (.resetRequest(resetRequest), .clock(clock), .reset(reset));

    controlUnit dut_i (.*);

    bind controlUnit controlUnitAssertions assertions_i (.*);

    // ****************************************
    // Reference model
    // ****************************************

    function automatic logic [31:0] nextRandom();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic phaseT phaseFor(input instrClassT cls);
        case (cls)
            clsAdd:  return phAdd;
            clsSub:  return phSub;
            clsAnd:  return phAnd;
            clsSll:  return phSll;
            clsSlt:  return phSlt;
            clsAddi: return phAddi;
            clsJump: return phJump;
            clsHalt: return phHalt;
            default: return phFetch;
        endcase
    endfunction

    function automatic int executeLength(input phaseT ph);
        case (ph)
            phSll:         return 3;
            phSlt, phJump: return 1;
            default:       return 2;
        endcase
    endfunction

    function automatic wordT expectedWord(input phaseT ph, input logic [`STEP_WIDTH-1:0] st,
                                          input logic rst);
        wordT w;
        w = '0;
        if (rst || ph == phHalt) begin
            w.strobes[rstBit] = 1'b1;
            return w;
        end
        case (ph)
            phFetch: begin
                if (st <= 3) begin
                    w.aluOp = aluAdd;                // PC + 4
                    w.srcB  = srcBFour;
                end
                if (st == 3) begin
                    w.strobes[pcBit] = 1'b1;
                    w.strobes[irBit] = 1'b1;
                end
                if (st == 4) begin
                    w.strobes[aBit] = 1'b1;
                    w.strobes[bBit] = 1'b1;
                    w.srcB          = srcBFour;
                end
            end
            phAdd, phSub, phAnd: begin
                w.aluOp = (ph == phSub) ? aluSub : ((ph == phAnd) ? aluAnd : aluAdd);
                w.strobes[aluOutBit] = 1'b1;
                w.strobes[srcABit]   = 1'b1;
                w.srcB               = srcBRegB;
                if (st == 1) begin
                    w.strobes[regBit] = 1'b1;
                    w.regDest         = destRd;
                end
            end
            phAddi: begin
                w.aluOp            = aluAdd;
                w.strobes[srcABit] = 1'b1;
                if (st == 0) begin
                    w.strobes[aluOutBit] = 1'b1;
                    w.srcB               = srcBImm;
                end else begin
                    w.strobes[regBit] = 1'b1;
                    w.regDest         = destRt;
                end
            end
            phSll: begin
                w.regDest           = destRd;
                w.memToReg          = wbShift;
                w.shiftOp           = (st == 0) ? shLoad : shLeft;
                w.strobes[shAmtBit] = (st == 0);
                w.strobes[shSrcBit] = (st == 0);
                w.strobes[regBit]   = (st == 2);
            end
            phSlt: begin
                w.aluOp            = aluLess;
                w.strobes[srcABit] = 1'b1;
                w.strobes[regBit]  = 1'b1;
                w.regDest          = destRd;
                w.memToReg         = wbLess;
            end
            phJump: begin
                w.strobes[pcBit]    = 1'b1;
                w.strobes[pcSrcBit] = 1'b1;
            end
        endcase
        return w;
    endfunction

    // ****************************************
    // Compare tasks
    // ****************************************

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        $display("[FAIL] %s got %h expected %h at %0t ns", name, got, exp, $time);
        errorCount++;
    endtask

    task automatic checkStrobes(input logic [10:0] got, input logic [10:0] exp);
        for (int i = 0; i < 11; i++) begin
            if (got[i] !== exp[i]) begin
                reportMismatch(strobeNames[i], got[i], exp[i]);
            end
        end
    endtask

    task automatic checkAluOp(input aluOpT got, input aluOpT exp);
        if (got !== exp) reportMismatch("aluOp", got, exp);
    endtask

    task automatic checkSrcB(input srcBT got, input srcBT exp);
        if (got !== exp) reportMismatch("srcBSelect", got, exp);
    endtask

    task automatic checkRegDest(input regDestT got, input regDestT exp);
        if (got !== exp) reportMismatch("regDestSelect", got, exp);
    endtask

    task automatic checkMemToReg(input memToRegT got, input memToRegT exp);
        if (got !== exp) reportMismatch("memToRegSelect", got, exp);
    endtask

    task automatic checkShiftOp(input shiftOpT got, input shiftOpT exp);
        if (got !== exp) reportMismatch("shiftOp", got, exp);
    endtask

    // Outputs follow the state, so values before the edge belong to the model's step
    always @(posedge clock) begin : compare
        wordT exp;
        exp = expectedWord(modelPhase, modelStep, reset);
        checkStrobes({pcWrite, irWrite, regWrite, aWrite, bWrite, aluOutWrite, srcASelect,
                      pcSource, shiftAmtSelect, shiftSrcSelect, resetOut}, exp.strobes);
        checkAluOp(aluOp, exp.aluOp);
        checkSrcB(srcBSelect, exp.srcB);
        checkRegDest(regDestSelect, exp.regDest);
        checkMemToReg(memToRegSelect, exp.memToReg);
        checkShiftOp(shiftOp, exp.shiftOp);
        if (reset) begin
            modelPhase = phFetch;
            modelStep  = '0;
        end else if (modelPhase == phFetch) begin
            if (modelStep == 5) begin
                modelPhase = phaseFor(currentClass);   // Decode step
                modelStep  = '0;
            end else begin
                modelStep++;
            end
        end else if (modelPhase == phHalt) begin
            haltCycles++;
        end else if (modelStep == executeLength(modelPhase) - 1) begin
            modelPhase = phFetch;
            modelStep  = '0;
        end else begin
            modelStep++;
        end
    end

    // ****************************************
    // Stimulus
    // ****************************************

    task automatic setInstruction(input int kind);
        logic [31:0] r;
        r      = nextRandom();
        offset = r[31:16];                           // Bits above funct are ignored
        case (kind)
            0, 1, 2, 3, 4: begin
                opcode       = opR;
                offset[5:0]  = rFuncts[kind];
                currentClass = rClasses[kind];
            end
            5: begin
                opcode       = opAddi;
                currentClass = clsAddi;
            end
            6: begin
                opcode       = opJump;
                currentClass = clsJump;
            end
            7: begin
                opcode       = badOpcodes[r[1:0]];
                currentClass = clsInvalid;
            end
            8: begin
                opcode       = opR;
                offset[5:0]  = badFuncts[r[3:2]];
                currentClass = clsInvalid;
            end
            default: begin
                opcode       = opHalt;
                currentClass = clsHalt;
            end
        endcase
    endtask

    // Drive during fetch step 0 and hold until the next fetch
    task automatic runInstruction(input int kind);
        while (!(modelPhase == phFetch && modelStep == 0)) @(negedge clock);
        setInstruction(kind);
        do @(negedge clock); while (modelPhase == phFetch && modelStep == 0);
    endtask

    initial begin : stimulus
        int testErrors;
        int kind;
        resetRequest = 1'b0;
        opcode       = opR;
        offset       = `OFFSET_WIDTH'(fnAdd);
        currentClass = clsAdd;                       // First instruction, held through reset

        @(negedge reset);
        @(negedge clock);
        $display("Test reset: %0d errors", errorCount);

        testErrors = errorCount;
        for (int k = 0; k < 9; k++) begin
            runInstruction(k);
        end
        $display("Test directed classes: %0d errors", errorCount - testErrors);

        testErrors = errorCount;
        for (int k = 0; k < randomCount; k++) begin
            kind = int'((nextRandom() >> 16) % 9);
            runInstruction(kind);
        end
        $display("Test random stream of %0d: %0d errors", randomCount, errorCount - testErrors);

        testErrors = errorCount;
        runInstruction(9);
        while (modelPhase != phHalt) @(negedge clock);
        repeat (20) @(negedge clock);
        resetRequest = 1'b1;
        @(negedge clock);
        resetRequest = 1'b0;
        runInstruction(0);
        runInstruction(6);
        while (!(modelPhase == phFetch && modelStep == 0)) @(negedge clock);
        $display("Test halt: %0d cycles held, %0d errors", haltCycles, errorCount - testErrors);

        $display("Done: %0d check errors, %0d assertion failures", errorCount,
                 dut_i.assertions_i.failureCount);
        if (errorCount == 0 && dut_i.assertions_i.failureCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #((instrCount * 10 + 50) * cycleNs);
        $display("Timeout after %0d cycles", instrCount * 10 + 50);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

/* sources.f */
+incdir+verilog
verilog/isaPkg.sv
verilog/controlPkg.sv
verilog/instrDecoder.sv
verilog/stepSequencer.sv
verilog/controlWordGen.sv
verilog/controlUnit.sv
tb/clockGen.sv
tb/controlUnit_sva.sv
tb/controlUnitTb.sv

/* Bender.yml */
package:
  name: controlUnit

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/isaPkg.sv
      - verilog/controlPkg.sv
      - verilog/instrDecoder.sv
      - verilog/stepSequencer.sv
      - verilog/controlWordGen.sv
      - verilog/controlUnit.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tb/clockGen.sv
      - tb/controlUnit_sva.sv
      - tb/controlUnitTb.sv
